// File: hw/issue_pkg.sv
package issue_pkg;

    // --------------------------------------------------
    // Basic widths
    // --------------------------------------------------
    localparam int NUM_TAGS_MAX = 16;
    localparam int TAG_W        = $clog2(NUM_TAGS_MAX);

    typedef logic [31:0]      data_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [31:0]      pc_t;
    // Tag 0 marks a value with no pending producer
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_ADDI
    } alu_op_e;

    // --------------------------------------------------
    // Payloads between the blocks
    // --------------------------------------------------
    typedef struct packed {
        alu_op_e  op;
        pc_t      pc;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
    } dispatch_t;

    typedef struct packed {
        alu_op_e op;
        pc_t     pc;
        data_t   imm;
        tag_t    tag;
        tag_t    src1_tag;
        data_t   src1_data;
        tag_t    src2_tag;
        data_t   src2_data;
    } rs_entry_t;

    typedef struct packed {
        alu_op_e op;
        pc_t     pc;
        data_t   imm;
        tag_t    tag;
        data_t   src1_data;
        data_t   src2_data;
    } issue_t;

    typedef struct packed {
        tag_t  tag;
        pc_t   pc;
        data_t data;
    } result_t;

endpackage

// File: hw/dispatch_unit.sv
`timescale 1ns/10ps

module dispatch_unit #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  disp_req,
    input  issue_pkg::dispatch_t  disp,
    output logic                  disp_ack,
    input  logic [NUM_ENTRIES-1:0] free_mask,
    input  logic                  res_valid,
    input  issue_pkg::result_t    res,
    output logic                  alloc_valid,
    output issue_pkg::rs_entry_t  alloc
);

    typedef enum logic {
        DISP_IDLE,
        DISP_ACK
    } disp_state_e;

    disp_state_e        state;
    issue_pkg::data_t   regs [32];
    issue_pkg::tag_t    rename_tag [32];

    issue_pkg::tag_t    free_tag;
    logic               accept;
    issue_pkg::tag_t    src1_tag;
    issue_pkg::data_t   src1_data;
    issue_pkg::tag_t    src2_tag;
    issue_pkg::data_t   src2_data;

    // Lowest free station entry gives the new tag
    always_comb begin
        free_tag = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                free_tag = issue_pkg::tag_t'(i + 1);
            end
        end
    end

    assign accept   = (state == DISP_IDLE) && disp_req && (|free_mask);
    assign disp_ack = (state == DISP_ACK);

    // --------------------------------------------------
    // Operand read with result bus bypass
    // --------------------------------------------------
    always_comb begin
        src1_tag  = rename_tag[disp.rs1];
        src1_data = regs[disp.rs1];
        if (src1_tag != '0 && res_valid && res.tag == src1_tag) begin
            src1_tag  = '0;
            src1_data = res.data;
        end

        src2_tag  = rename_tag[disp.rs2];
        src2_data = regs[disp.rs2];
        if (src2_tag != '0 && res_valid && res.tag == src2_tag) begin
            src2_tag  = '0;
            src2_data = res.data;
        end
        // ADDI never waits on rs2
        if (disp.op == issue_pkg::OP_ADDI) begin
            src2_tag  = '0;
            src2_data = '0;
        end
    end

    assign alloc_valid = accept;
    assign alloc = '{op:        disp.op,
                     pc:        disp.pc,
                     imm:       disp.imm,
                     tag:       free_tag,
                     src1_tag:  src1_tag,
                     src1_data: src1_data,
                     src2_tag:  src2_tag,
                     src2_data: src2_data};

    // --------------------------------------------------
    // Handshake FSM, register file and rename table
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DISP_IDLE;
            for (int i = 0; i < 32; i++) begin
                regs[i]       <= '0;
                rename_tag[i] <= '0;
            end
        end else begin
            case (state)
                DISP_IDLE: if (accept) state <= DISP_ACK;
                DISP_ACK:  if (!disp_req) state <= DISP_IDLE;
                default:   state <= DISP_IDLE;
            endcase

            // Only the newest producer of a register may write it
            if (res_valid) begin
                for (int i = 1; i < 32; i++) begin
                    if (rename_tag[i] == res.tag) begin
                        regs[i]       <= res.data;
                        rename_tag[i] <= '0;
                    end
                end
            end

            // Later in the block so a new rename wins over a same-cycle clear
            if (accept && disp.rd != '0) begin
                rename_tag[disp.rd] <= free_tag;
            end
        end
    end

endmodule

// File: hw/reservation_station.sv
`timescale 1ns/10ps

module reservation_station #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc_valid,
    input  issue_pkg::rs_entry_t   alloc,
    input  logic                   res_valid,
    input  issue_pkg::result_t     res,
    output logic [NUM_ENTRIES-1:0] free_mask,
    output logic                   iss_valid,
    output issue_pkg::issue_t      iss
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    issue_pkg::rs_entry_t   entries [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] occupied;
    logic [NUM_ENTRIES-1:0] ready;
    logic [NUM_ENTRIES-1:0] alu_busy;

    logic [IDX_W-1:0]       alloc_idx;
    logic [IDX_W-1:0]       iss_idx;
    logic [IDX_W-1:0]       sel_idx;
    logic                   sel_any;

    // Tag n lives in entry n-1
    assign alloc_idx = IDX_W'(alloc.tag - issue_pkg::tag_t'(1));
    assign iss_idx   = IDX_W'(iss.tag - issue_pkg::tag_t'(1));

    // --------------------------------------------------
    // Ready selection and free tags
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ready[i] = occupied[i] &&
                       entries[i].src1_tag == '0 &&
                       entries[i].src2_tag == '0;
        end
    end

    always_comb begin
        sel_any = 1'b0;
        sel_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_any = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
    end

    // Tag in the ALU stays reserved until its result is broadcast
    always_comb begin
        alu_busy = '0;
        if (iss_valid) begin
            alu_busy[iss_idx] = 1'b1;
        end
    end

    assign free_mask = ~occupied & ~alu_busy;

    // --------------------------------------------------
    // Occupancy and issue strobe
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupied  <= '0;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= sel_any;
            if (sel_any) begin
                occupied[sel_idx] <= 1'b0;
            end
            if (alloc_valid) begin
                occupied[alloc_idx] <= 1'b1;
            end
        end
    end

    // Entry storage with wakeup from the result bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (res_valid && occupied[i]) begin
                if (entries[i].src1_tag == res.tag) begin
                    entries[i].src1_tag  <= '0;
                    entries[i].src1_data <= res.data;
                end
                if (entries[i].src2_tag == res.tag) begin
                    entries[i].src2_tag  <= '0;
                    entries[i].src2_data <= res.data;
                end
            end
        end
        if (alloc_valid) begin
            entries[alloc_idx] <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_any) begin
            iss <= '{op:        entries[sel_idx].op,
                     pc:        entries[sel_idx].pc,
                     imm:       entries[sel_idx].imm,
                     tag:       entries[sel_idx].tag,
                     src1_data: entries[sel_idx].src1_data,
                     src2_data: entries[sel_idx].src2_data};
        end
    end

endmodule

// File: hw/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               iss_valid,
    input  issue_pkg::issue_t  iss,
    output logic               res_valid,
    output issue_pkg::result_t res
);

    issue_pkg::data_t op_a;
    issue_pkg::data_t op_b;
    issue_pkg::data_t result;

    assign op_a = iss.src1_data;
    assign op_b = iss.src2_data;

    // --------------------------------------------------
    // Operation decode
    // --------------------------------------------------
    always_comb begin
        case (iss.op)
            issue_pkg::OP_ADD:  result = op_a + op_b;
            issue_pkg::OP_SUB:  result = op_a - op_b;
            issue_pkg::OP_AND:  result = op_a & op_b;
            issue_pkg::OP_OR:   result = op_a | op_b;
            issue_pkg::OP_XOR:  result = op_a ^ op_b;
            // Shift amount from the low five bits only
            issue_pkg::OP_SLL:  result = op_a << op_b[4:0];
            issue_pkg::OP_SRL:  result = op_a >> op_b[4:0];
            issue_pkg::OP_ADDI: result = op_a + iss.imm;
            default:            result = '0;
        endcase
    end

    // --------------------------------------------------
    // Result bus register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res <= '{tag:  iss.tag,
                     pc:   iss.pc,
                     data: result};
        end
    end

endmodule

// File: hw/issue_top.sv
`timescale 1ns/10ps

module issue_top #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 disp_req,
    input  issue_pkg::dispatch_t disp,
    output logic                 disp_ack,
    output logic                 res_valid,
    output issue_pkg::result_t   res
);

    logic                   alloc_valid;
    issue_pkg::rs_entry_t   alloc;
    logic [NUM_ENTRIES-1:0] free_mask;
    logic                   iss_valid;
    issue_pkg::issue_t      iss;

    // Rename, register file and dispatch handshake
    dispatch_unit #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) dispatch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp_req    (disp_req),
        .disp        (disp),
        .disp_ack    (disp_ack),
        .free_mask   (free_mask),
        .res_valid   (res_valid),
        .res         (res),
        .alloc_valid (alloc_valid),
        .alloc       (alloc)
    );

    reservation_station #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) station_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_valid (alloc_valid),
        .alloc       (alloc),
        .res_valid   (res_valid),
        .res         (res),
        .free_mask   (free_mask),
        .iss_valid   (iss_valid),
        .iss         (iss)
    );

    // Sole driver of the result bus
    alu_unit alu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss       (iss),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a falling edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verif/issue_tb.sv
`timescale 1ns/10ps

module issue_tb;

    localparam int NUM_ENTRIES = 8;
    localparam int N_INDEP     = 8;
    localparam int N_CHAIN     = 12;
    localparam int N_FULL      = 32;
    localparam int N_RAND      = 60;
    localparam int TOTAL_INSTR = N_INDEP + N_CHAIN + N_FULL + N_RAND;

    logic                 clk;
    logic                 rst_n;
    logic                 disp_req;
    issue_pkg::dispatch_t disp;
    logic                 disp_ack;
    logic                 res_valid;
    issue_pkg::result_t   res;

    integer               seed = 32'hf0f5_6079;
    issue_pkg::data_t     model_regs [32];
    issue_pkg::data_t     exp_data [issue_pkg::pc_t];
    bit                   seen_pc [issue_pkg::pc_t];
    issue_pkg::pc_t       next_pc;
    int                   sent_count;
    int                   reported_count;
    int                   accepted;
    int                   results;
    int                   max_pending;
    logic                 ack_prev;

    tb_clock #(
        .PERIOD       (8),
        .RESET_CYCLES (5)
    ) clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_top #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .disp_req  (disp_req),
        .disp      (disp),
        .disp_ack  (disp_ack),
        .res_valid (res_valid),
        .res       (res)
    );

    // --------------------------------------------------
    // Reference model and checks
    // --------------------------------------------------
    function automatic issue_pkg::data_t alu_reference(input issue_pkg::alu_op_e op,
                                                       input issue_pkg::data_t a,
                                                       input issue_pkg::data_t b,
                                                       input issue_pkg::data_t imm);
        case (op)
            issue_pkg::OP_ADD:  return a + b;
            issue_pkg::OP_SUB:  return a - b;
            issue_pkg::OP_AND:  return a & b;
            issue_pkg::OP_OR:   return a | b;
            issue_pkg::OP_XOR:  return a ^ b;
            issue_pkg::OP_SLL:  return a << b[4:0];
            issue_pkg::OP_SRL:  return a >> b[4:0];
            default:            return a + imm;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_low(input string name, input logic got);
        if (got !== 1'b0) begin
            abort_run($sformatf("[FAIL] %0t ns: %s is %b, expected 0", $time, name, got));
        end
    endtask

    task automatic check_result(input issue_pkg::result_t got);
        if (!exp_data.exists(got.pc)) begin
            abort_run($sformatf("Result bus reported pc 0x%08h, which was never sent", got.pc));
        end else if (seen_pc.exists(got.pc)) begin
            abort_run($sformatf("Result bus reported pc 0x%08h a second time", got.pc));
        end else begin
            seen_pc[got.pc] = 1'b1;
            reported_count++;
            // Tags 1..NUM_ENTRIES are the only ones handed out
            if ($isunknown(got.tag) || got.tag == '0 ||
                got.tag > issue_pkg::tag_t'(NUM_ENTRIES)) begin
                abort_run($sformatf("[FAIL] %0t ns: pc 0x%08h carries tag %0d, outside 1..%0d",
                                    $time, got.pc, got.tag, NUM_ENTRIES));
            end else if (got.data !== exp_data[got.pc]) begin
                abort_run($sformatf("[FAIL] %0t ns: pc 0x%08h expected 0x%08h got 0x%08h",
                                    $time, got.pc, exp_data[got.pc], got.data));
            end
        end
    endtask

    // Model is updated in program order when the instruction is sent
    task automatic send_instr(input issue_pkg::alu_op_e op, input issue_pkg::reg_idx_t rd,
                              input issue_pkg::reg_idx_t rs1, input issue_pkg::reg_idx_t rs2,
                              input issue_pkg::data_t imm);
        issue_pkg::dispatch_t d;
        issue_pkg::data_t     val;
        val = alu_reference(op, model_regs[rs1], model_regs[rs2], imm);
        exp_data[next_pc] = val;
        if (rd != '0) begin
            model_regs[rd] = val;
        end
        d.op  = op;
        d.pc  = next_pc;
        d.rd  = rd;
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.imm = imm;
        next_pc = next_pc + 32'd4;
        sent_count++;

        disp     = d;
        disp_req = 1'b1;
        do @(negedge clk); while (!disp_ack);
        disp_req = 1'b0;
        do @(negedge clk); while (disp_ack);
    endtask

    task automatic wait_drain();
        while (reported_count < sent_count) @(negedge clk);
    endtask

    // --------------------------------------------------
    // Compare process and occupancy monitor
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (disp_ack && !ack_prev) begin
                if (accepted - results >= NUM_ENTRIES) begin
                    abort_run("Dispatch accepted an instruction while the station was full");
                end
                accepted++;
                if (accepted - results > max_pending) begin
                    max_pending = accepted - results;
                end
            end
            if (res_valid) begin
                results++;
                check_result(res);
            end
        end
        ack_prev = disp_ack;
    end

    initial begin
        repeat (TOTAL_INSTR * 40 + 200) @(posedge clk);
        abort_run("Timeout: not every instruction produced a result in time");
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0]         rnd;
        issue_pkg::reg_idx_t prev_rd;
        issue_pkg::reg_idx_t rd;

        disp_req       = 1'b0;
        disp           = '0;
        next_pc        = 32'h0000_1000;
        sent_count     = 0;
        reported_count = 0;
        accepted       = 0;
        results        = 0;
        max_pending    = 0;
        ack_prev       = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        // Reset: handshake and result bus stay quiet
        repeat (4) begin
            @(negedge clk);
            check_low("disp_ack", disp_ack);
            check_low("res_valid", res_valid);
        end
        wait (rst_n);
        repeat (2) begin
            @(negedge clk);
            check_low("disp_ack", disp_ack);
            check_low("res_valid", res_valid);
        end

        // Independent ADDI from r0
        for (int i = 0; i < N_INDEP; i++) begin
            rnd = $random(seed);
            send_instr(issue_pkg::OP_ADDI, issue_pkg::reg_idx_t'(i + 1), '0,
                       issue_pkg::reg_idx_t'(rnd[4:0]), $random(seed));
        end
        wait_drain();

        // Dependent chain through the previous rd
        prev_rd = 5'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = issue_pkg::reg_idx_t'(1 + ((i + 1) % 6));
            send_instr(issue_pkg::alu_op_e'(3'(i)), rd, prev_rd,
                       issue_pkg::reg_idx_t'(i % 8), $random(seed));
            prev_rd = rd;
        end
        wait_drain();

        // Long self-dependent chain drains slower than dispatch and fills the station
        for (int i = 0; i < N_FULL; i++) begin
            send_instr(issue_pkg::OP_ADDI, 5'd9, 5'd9, 5'd0, issue_pkg::data_t'(i + 1));
        end
        wait_drain();
        if (max_pending < NUM_ENTRIES) begin
            abort_run("The station never filled during the back-pressure test");
        end

        // Random mix with register reuse and r0
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            send_instr(issue_pkg::alu_op_e'(rnd[2:0]), {2'b00, rnd[5:3]}, {2'b00, rnd[8:6]},
                       {1'b0, rnd[12:9]}, $random(seed));
        end
        wait_drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: tomasulo_issue.f
hw/issue_pkg.sv
hw/dispatch_unit.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/issue_top.sv
verif/tb_clock.sv
verif/issue_tb.sv
